//--- src/sobel_settings.svh
// Image geometry and datapath widths for the Sobel edge detector, included wherever sizes are needed
`ifndef SOBEL_SETTINGS_SVH
`define SOBEL_SETTINGS_SVH

//------------------------------------------------------------
// Frame geometry
//------------------------------------------------------------

`define SOBEL_IMG_HDISP 640	// Pixels per line, sets line buffer depth
`define SOBEL_IMG_VDISP 480	// Lines per frame

//------------------------------------------------------------
// Datapath widths
//------------------------------------------------------------

// Luminance sample width
`define SOBEL_PIX_W 8

// One square-root stage per result bit
// Magnitude of a 21-bit square sum needs 11 bits
`define SOBEL_SQRT_STAGES 11

`endif

//--- src/sobel_pkg.sv
// Shared types for the Sobel edge detector, imported by every design module and the testbench
`include "sobel_settings.svh"

package sobel_pkg;

	// Camera timing, travels with every pipeline stage
	typedef struct packed {
		logic vsync;	// High for the whole frame
		logic href;	// High during the active part of a line
		logic clken;	// Pixel strobe
	} video_sync_t;

	typedef logic [`SOBEL_PIX_W-1:0] pixel_t;	// One luminance sample

	// 3x3 neighbourhood, row 1 is the oldest line, column 1 the oldest pixel
	typedef struct packed {
		pixel_t p11, p12, p13;
		pixel_t p21, p22, p23;
		pixel_t p31, p32, p33;
	} window_t;

	typedef logic [`SOBEL_PIX_W+1:0]   grad_t;	// |G| up to 4 * 255
	typedef logic [2*`SOBEL_PIX_W+4:0] sq_t;	// Gx^2 + Gy^2
	typedef logic [`SOBEL_SQRT_STAGES-1:0] mag_t;	// Floor of the square root

	// Which line buffer rows hold real data for the current line
	typedef enum logic [1:0] {
		ROW_FIRST,	// Top line, both older rows padded
		ROW_SECOND,	// Only row r-1 valid
		ROW_FULL	// Both buffers valid
	} row_state_e;

endpackage

//--- src/window_3x3_gen.sv
// 3x3 window generator, takes camera-timing pixels and presents a zero-padded window 2 clocks later
`include "sobel_settings.svh"

module window_3x3_gen
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  sobel_pkg::video_sync_t in_sync,
	input  sobel_pkg::pixel_t      in_pix,
	output sobel_pkg::video_sync_t win_sync,
	output sobel_pkg::window_t     win
);
	import sobel_pkg::*;

	localparam int COL_W = $clog2(`SOBEL_IMG_HDISP);

	logic             accept;	// Pixel taken at the input
	logic             accept_d1;
	logic [COL_W-1:0] col;	// Column of the incoming pixel
	row_state_e       row_state;

	pixel_t line_prev [`SOBEL_IMG_HDISP];	// Row r-1
	pixel_t line_old  [`SOBEL_IMG_HDISP];	// Row r-2

	video_sync_t sync_d1;
	pixel_t      top_d1;	// Oldest row, zero when not yet filled
	pixel_t      mid_d1;
	pixel_t      bot_d1;	// Current row

	assign accept    = in_sync.clken & in_sync.href;
	assign accept_d1 = sync_d1.clken & sync_d1.href;

	//------------------------------------------------------------
	// Column counter and row tracking
	//------------------------------------------------------------

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			col <= '0;
		else if (!in_sync.href)
			col <= '0;	// Restart for the next line
		else if (accept)
			col <= col + 1'b1;
	end

	// Advances at the end of each line, restarts between frames
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			row_state <= ROW_FIRST;
		else if (!in_sync.vsync)
			row_state <= ROW_FIRST;
		else if (sync_d1.href && !in_sync.href)	// href falling edge
		begin
			case (row_state)
				ROW_FIRST:  row_state <= ROW_SECOND;
				ROW_SECOND: row_state <= ROW_FULL;
				default:    row_state <= ROW_FULL;
			endcase
		end
	end

	//------------------------------------------------------------
	// Line buffers, read old data and write new in one clock
	//------------------------------------------------------------

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			line_prev[col] <= in_pix;
			line_old[col]  <= line_prev[col];	// Previous line moves down one row
		end
	end

	// Stage 1, column of three with top-edge padding
	always_ff @(posedge clk)
	begin
		top_d1 <= (row_state == ROW_FULL)  ? line_old[col]  : '0;
		mid_d1 <= (row_state != ROW_FIRST) ? line_prev[col] : '0;
		bot_d1 <= in_pix;
	end

	//------------------------------------------------------------
	// Stage 2, column shift registers
	//------------------------------------------------------------

	// Cleared while href is low, so each line starts with zero columns on the left
	always_ff @(posedge clk)
	begin
		if (!sync_d1.href)
			win <= '0;
		else if (accept_d1)
		begin
			win.p11 <= win.p12;
			win.p12 <= win.p13;
			win.p13 <= top_d1;
			win.p21 <= win.p22;
			win.p22 <= win.p23;
			win.p23 <= mid_d1;
			win.p31 <= win.p32;
			win.p32 <= win.p33;
			win.p33 <= bot_d1;	// Newest pixel
		end
	end

	// Sync follows the two data stages
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			sync_d1  <= '0;
			win_sync <= '0;
		end
		else
		begin
			sync_d1  <= in_sync;
			win_sync <= sync_d1;
		end
	end

endmodule

//--- src/isqrt_pipe.sv
// Pipelined non-restoring integer square root, one new result every clock after a fixed latency
`include "sobel_settings.svh"

module isqrt_pipe
(
	input  logic            clk,
	input  logic            rst_n,
	input  sobel_pkg::sq_t  sq,
	input  logic            in_valid,
	output sobel_pkg::mag_t root,
	output logic            out_valid
);
	import sobel_pkg::*;

	localparam int N    = `SOBEL_SQRT_STAGES;	// Result bits, one per stage
	localparam int RW   = N + 2;	// Signed remainder width
	localparam int RADW = 2 * N;	// Radicand, two bits consumed per stage

	typedef logic signed [RW-1:0] rem_t;
	typedef logic [RADW-1:0]      rad_t;

	// State handed from one stage to the next
	typedef struct packed {
		rem_t rem;	// Partial remainder, may go negative
		mag_t root;	// Result bits decided so far
	} step_t;

	rad_t         rad_in;
	step_t        st_q  [N];
	rad_t         rad_q [N];	// Radicand bits not yet consumed
	logic [N-1:0] vld_q;

	assign rad_in = rad_t'(sq);	// Zero-extend to an even bit count

	// One root bit, subtract the trial value on a positive remainder, add it back otherwise
	function automatic step_t nr_step(input rem_t rem, input mag_t q, input logic [1:0] pair);
		rem_t  shifted;
		step_t res;
		shifted = {rem[RW-3:0], pair};	// Bring down the next two bits
		if (!rem[RW-1])
			res.rem = shifted - {q, 2'b01};
		else
			res.rem = shifted + {q, 2'b11};
		res.root = {q[N-2:0], ~res.rem[RW-1]};	// Bit is 1 when remainder stays >= 0
		return res;
	endfunction

	//------------------------------------------------------------
	// Datapath stages
	//------------------------------------------------------------

	always_ff @(posedge clk)
	begin
		st_q[0]  <= nr_step('0, '0, rad_in[RADW-1 -: 2]);
		rad_q[0] <= rad_in << 2;
		for (int s = 1; s < N; s++)
		begin
			st_q[s]  <= nr_step(st_q[s-1].rem, st_q[s-1].root, rad_q[s-1][RADW-1 -: 2]);
			rad_q[s] <= rad_q[s-1] << 2;
		end
	end

	// Valid tag rides along with the data
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			vld_q <= '0;
		else
			vld_q <= {vld_q[N-2:0], in_valid};
	end

	assign root      = st_q[N-1].root;	// Floor square root after N clocks
	assign out_valid = vld_q[N-1];

endmodule

//--- src/sobel_edge_detector.sv
// Sobel magnitude and threshold stages, turns each 3x3 window into a one-bit edge flag 15 clocks later
`include "sobel_settings.svh"

module sobel_edge_detector
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  sobel_pkg::video_sync_t win_sync,
	input  sobel_pkg::window_t     win,
	input  sobel_pkg::pixel_t      threshold,
	output sobel_pkg::video_sync_t out_sync,
	output logic                   edge_bit
);
	import sobel_pkg::*;

	// Two gradient stages, the square sum, the root and the compare
	localparam int LAT = `SOBEL_SQRT_STAGES + 4;

	grad_t gx_pos, gx_neg;	// Right and left columns
	grad_t gy_pos, gy_neg;	// Top and bottom rows
	grad_t gx, gy;
	sq_t   square;
	mag_t  root;
	logic  root_valid;	// Delayed href from the root pipeline

	video_sync_t [LAT-1:0] sync_dly;

	// Weighted 1-2-1 tap sum
	function automatic grad_t tap_sum(input pixel_t a, input pixel_t b, input pixel_t c);
		return grad_t'(a) + grad_t'({b, 1'b0}) + grad_t'(c);
	endfunction

	function automatic grad_t abs_diff(input grad_t a, input grad_t b);
		return (a >= b) ? a - b : b - a;
	endfunction

	//------------------------------------------------------------
	// Gradients and square sum
	//------------------------------------------------------------

	always_ff @(posedge clk)
	begin
		// Stage 1
		gx_pos <= tap_sum(win.p13, win.p23, win.p33);
		gx_neg <= tap_sum(win.p11, win.p21, win.p31);
		gy_pos <= tap_sum(win.p11, win.p12, win.p13);
		gy_neg <= tap_sum(win.p31, win.p32, win.p33);
		// Stage 2, absolute gradients
		gx <= abs_diff(gx_pos, gx_neg);
		gy <= abs_diff(gy_pos, gy_neg);
		// Stage 3
		square <= sq_t'(gx) * sq_t'(gx) + sq_t'(gy) * sq_t'(gy);
	end

	// Square root, tagged with href of the square sum stage
	isqrt_pipe u_isqrt
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.sq        (square),
		.in_valid  (sync_dly[2].href),
		.root      (root),
		.out_valid (root_valid)
	);

	//------------------------------------------------------------
	// Threshold and sync delay
	//------------------------------------------------------------

	// Flag only inside the active line
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			edge_bit <= 1'b0;
		else
			edge_bit <= root_valid && (root >= mag_t'(threshold));
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			sync_dly <= '0;
		else
			sync_dly <= {sync_dly[LAT-2:0], win_sync};
	end

	assign out_sync = sync_dly[LAT-1];	// Lines up with edge_bit

endmodule

//--- src/edge_detect_top.sv
// Top level of the streaming Sobel edge detector, camera-timing pixels in and edge flags out
module edge_detect_top
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  sobel_pkg::video_sync_t in_sync,
	input  sobel_pkg::pixel_t      in_pix,
	input  sobel_pkg::pixel_t      threshold,	// Hold steady through a frame
	output sobel_pkg::video_sync_t out_sync,	// in_sync 17 clocks later
	output logic                   edge_bit
);
	import sobel_pkg::*;

	video_sync_t win_sync;	// Sync aligned with the window
	window_t     win;

	// Neighbourhood, 2 clocks
	window_3x3_gen u_window
	(
		.clk      (clk),
		.rst_n    (rst_n),
		.in_sync  (in_sync),
		.in_pix   (in_pix),
		.win_sync (win_sync),
		.win      (win)
	);

	// Magnitude and threshold, 15 clocks
	sobel_edge_detector u_sobel
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.win_sync  (win_sync),
		.win       (win),
		.threshold (threshold),
		.out_sync  (out_sync),
		.edge_bit  (edge_bit)
	);

endmodule

//--- sim/edge_detect_sva.sv
// Timing and reset assertions for the Sobel detector, bound into sobel_edge_detector from here
module edge_detect_sva
(
	input logic                   clk,
	input logic                   rst_n,
	input sobel_pkg::video_sync_t win_sync,
	input sobel_pkg::video_sync_t out_sync,
	input logic                   edge_bit
);
	import sobel_pkg::*;

	logic [4:0] cyc;	// Clocks since reset, saturates once the pipeline is full

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			cyc <= '0;
		else if (cyc < 5'd20)
			cyc <= cyc + 1'b1;
	end

	// Sync passes through the detector unchanged, 15 clocks late
	sync_delay: assert property (@(posedge clk) disable iff (!rst_n || cyc < 5'd16)
		out_sync == $past(win_sync, 15))
		else $error("out_sync is not win_sync delayed by 15 clocks");

	// No flag outside the active line
	flag_in_line: assert property (@(posedge clk) !out_sync.href |-> !edge_bit)
		else $error("edge_bit high while href is low");

	reset_quiet: assert property (@(posedge clk) !rst_n |-> (out_sync == '0 && !edge_bit))
		else $error("outputs not zero during reset");

endmodule

bind sobel_edge_detector edge_detect_sva u_sva (.*);

//--- sim/edge_detect_tb.sv
// Testbench for the Sobel edge detector top level that runs a table of frames against a pixel model
module edge_detect_tb;
	import sobel_pkg::*;

	localparam int W             = 8;	// Frame width in simulation
	localparam int H             = 6;	// Frame height in simulation
	localparam int NROWS         = 6;	// Table rows, one frame each
	localparam int SYNC_LAT      = 17;	// in_sync to out_sync
	localparam int DRAIN_TIMEOUT = 400;

	typedef enum logic [2:0] {PAT_FLAT, PAT_VSTEP, PAT_HSTEP, PAT_RAMP, PAT_RANDOM} pattern_e;

	// One frame of the test
	typedef struct packed {
		pattern_e pat;
		pixel_t   thr;
		int       exp_count;	// Negative when there is no hand count
	} frame_cfg_t;

	logic        clk;
	logic        rst_n;
	video_sync_t in_sync;
	pixel_t      in_pix;
	pixel_t      threshold;
	video_sync_t out_sync;
	logic        edge_bit;

	integer      seed;
	int          frm [H][W];	// Current frame in row-major order
	logic        exp_q [$];	// Expected flags in output order
	video_sync_t hist [SYNC_LAT];	// Recent input sync with the newest first
	int          edge_count;	// Flags seen in the current frame
	frame_cfg_t  cfg_table [NROWS];

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	edge_detect_top u_dut
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.in_sync   (in_sync),
		.in_pix    (in_pix),
		.threshold (threshold),
		.out_sync  (out_sync),
		.edge_bit  (edge_bit)
	);

	//------------------------------------------------------------
	// Reference model
	//------------------------------------------------------------

	function automatic int floor_sqrt(input int s);
		int k;
		k = 0;
		while ((k + 1) * (k + 1) <= s)
			k++;
		return k;
	endfunction

	// Zero padding above and left of the frame
	function automatic int pix_at(input int r, input int c);
		if (r < 0 || c < 0)
			return 0;
		return frm[r][c];
	endfunction

	function automatic logic model_bit(input int r, input int c, input int thr);
		int gx;
		int gy;
		gx = (pix_at(r-2, c) + 2 * pix_at(r-1, c) + pix_at(r, c))
			- (pix_at(r-2, c-2) + 2 * pix_at(r-1, c-2) + pix_at(r, c-2));	// Right minus left
		gy = (pix_at(r-2, c-2) + 2 * pix_at(r-2, c-1) + pix_at(r-2, c))
			- (pix_at(r, c-2) + 2 * pix_at(r, c-1) + pix_at(r, c));	// Top minus bottom
		if (gx < 0)
			gx = -gx;
		if (gy < 0)
			gy = -gy;
		return floor_sqrt(gx * gx + gy * gy) >= thr;
	endfunction

	task automatic fill_frame(input pattern_e pat);
		for (int r = 0; r < H; r++)
			for (int c = 0; c < W; c++)
				case (pat)
					PAT_FLAT:  frm[r][c] = 0;
					PAT_VSTEP: frm[r][c] = (c >= 4) ? 200 : 0;	// Step between columns 3 and 4
					PAT_HSTEP: frm[r][c] = (r >= 3) ? 200 : 0;
					PAT_RAMP:  frm[r][c] = 10 * c;
					default:   frm[r][c] = $random(seed) & 255;
				endcase
	endtask

	//------------------------------------------------------------
	// Compare tasks that stop at the first mismatch
	//------------------------------------------------------------

	task automatic check_bit(input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("ERROR at %0t: edge_bit is %b, expected %b", $time, got, exp);
			$display("TEST FAIL");
			$fatal(1, "edge flag mismatch");
		end
	endtask

	task automatic check_sync(input video_sync_t got, input video_sync_t exp);
		if (got !== exp)
		begin
			$display("ERROR at %0t: out_sync is %b, expected %b", $time, got, exp);
			$display("TEST FAIL");
			$fatal(1, "sync mismatch");
		end
	endtask

	task automatic check_count(input int got, input int exp, input int row);
		if (got != exp)
		begin
			$display("ERROR at %0t: frame %0d has %0d edges, expected %0d", $time, row, got, exp);
			$display("TEST FAIL");
			$fatal(1, "edge count mismatch");
		end
	endtask

	//------------------------------------------------------------
	// Frame driver
	//------------------------------------------------------------

	task automatic drive(input logic vs, input logic hr, input logic ce, input pixel_t p);
		@(posedge clk);
		in_sync <= '{vsync: vs, href: hr, clken: ce};
		in_pix  <= p;
	endtask

	// One blank clock between lines and random clken gaps inside a line
	task automatic send_frame();
		drive(1'b1, 1'b0, 1'b0, '0);
		drive(1'b1, 1'b0, 1'b0, '0);
		for (int r = 0; r < H; r++)
		begin
			for (int c = 0; c < W; c++)
			begin
				if (($random(seed) & 3) == 0)
					drive(1'b1, 1'b1, 1'b0, pixel_t'(frm[r][c]));	// Strobe gap
				drive(1'b1, 1'b1, 1'b1, pixel_t'(frm[r][c]));
			end
			drive(1'b1, 1'b0, 1'b0, '0);
		end
		repeat (3)
			drive(1'b0, 1'b0, 1'b0, '0);	// Frame gap
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (exp_q.size() != 0)
		begin
			@(posedge clk);
			n++;
			if (n > DRAIN_TIMEOUT)
			begin
				$display("Timed out waiting for the output pixels of the frame");
				$display("TEST FAIL");
				$fatal(1, "drain timeout");
			end
		end
	endtask

	//------------------------------------------------------------
	// Output monitor sampled on the falling edge
	//------------------------------------------------------------

	always @(negedge clk)
	begin
		logic exp_bit;
		check_sync(out_sync, hist[SYNC_LAT-1]);	// Input sync 17 clocks back
		if (out_sync.href && out_sync.clken)
		begin
			if (exp_q.size() == 0)
			begin
				$display("An output pixel arrived that matches no input pixel");
				$display("TEST FAIL");
				$fatal(1, "unexpected output pixel");
			end
			else
			begin
				exp_bit = exp_q.pop_front();
				check_bit(edge_bit, exp_bit);
				if (edge_bit)
					edge_count++;
			end
		end
		else if (!out_sync.href)
			check_bit(edge_bit, 1'b0);
		for (int k = SYNC_LAT - 1; k > 0; k--)
			hist[k] = hist[k-1];
		hist[0] = in_sync;
	end

	//------------------------------------------------------------
	// Main sequence
	//------------------------------------------------------------

	initial
	begin
		seed       = 32'h466e9d4f;
		rst_n      = 1'b0;
		in_sync    = '0;
		in_pix     = '0;
		threshold  = '0;
		edge_count = 0;
		for (int k = 0; k < SYNC_LAT; k++)
			hist[k] = '0;

		// Counts for fixed patterns worked out by hand
		cfg_table[0] = '{pat: PAT_FLAT,   thr: 8'd1,   exp_count: 0};
		cfg_table[1] = '{pat: PAT_VSTEP,  thr: 8'd100, exp_count: 16};
		cfg_table[2] = '{pat: PAT_HSTEP,  thr: 8'd100, exp_count: 18};
		cfg_table[3] = '{pat: PAT_RAMP,   thr: 8'd100, exp_count: 9};	// Hits root == 100
		cfg_table[4] = '{pat: PAT_RANDOM, thr: 8'd60,  exp_count: -1};
		cfg_table[5] = '{pat: PAT_RANDOM, thr: 8'd150, exp_count: -1};

		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		repeat (6) @(posedge clk);	// Outputs must stay zero while idle

		for (int i = 0; i < NROWS; i++)
		begin
			fill_frame(cfg_table[i].pat);
			for (int r = 0; r < H; r++)
				for (int c = 0; c < W; c++)
					exp_q.push_back(model_bit(r, c, int'(cfg_table[i].thr)));
			@(posedge clk);
			edge_count = 0;
			threshold <= cfg_table[i].thr;	// Steady for the whole frame
			send_frame();
			wait_drain();
			repeat (SYNC_LAT) @(posedge clk);	// Let the trailing sync flush
			if (cfg_table[i].exp_count >= 0)
				check_count(edge_count, cfg_table[i].exp_count, i);
		end

		$display("TEST PASS");
		$finish;
	end

endmodule

//--- compile.f
+incdir+src
src/sobel_pkg.sv
src/window_3x3_gen.sv
src/isqrt_pipe.sv
src/sobel_edge_detector.sv
src/edge_detect_top.sv
sim/edge_detect_sva.sv
sim/edge_detect_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= edge_detect_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
